/* hw/bp_defines.svh */
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// buffer geometry
`define BP_ENTRIES 16
`define BP_IDX_W 4

// instruction word address, byte address bits 31 down to 2
`define BP_WADDR_W 30

// rv32i major opcodes that train the buffer
`define BP_OP_BRANCH 7'b1100011
`define BP_OP_JAL 7'b1101111

// counter value given to a newly allocated entry
`define BP_CTR_ALLOC_T 2'd2
`define BP_CTR_ALLOC_NT 2'd1

// counter value from which the stored target is predicted
`define BP_CTR_TAKEN 2'd2

`endif

/* hw/bp_pkg.sv */
`include "bp_defines.svh"

package bp_pkg;

	// instruction word address
	typedef logic [`BP_WADDR_W-1:0] word_addr_t;

	// one branch target buffer entry
	typedef struct packed {
		logic       valid;
		word_addr_t tag;
		word_addr_t target;
		// 2-bit saturating direction counter
		logic [1:0] ctr;
	} btb_entry_t;

	// one resolved instruction coming back from execute
	typedef struct packed {
		logic        valid;
		word_addr_t  pc;
		logic [31:0] instr;
		logic        taken;
	} bp_update_t;

	// result of one associative lookup
	typedef struct packed {
		logic                 hit;
		logic [`BP_IDX_W-1:0] idx;
		// copy of the matching entry, don't care on a miss
		btb_entry_t           entry;
	} btb_lookup_t;

endpackage

/* hw/branch_target_decoder.sv */
`include "bp_defines.svh"

module branch_target_decoder
	import bp_pkg::*;
(
	input  logic [31:0] instr_i,
	input  word_addr_t  pc_i,
	output logic        is_ctrl_o,
	output word_addr_t  target_o
);

	logic [6:0] opcode;
	logic is_branch;
	logic is_jal;
	// immediates with the two byte offset bits dropped
	logic [10:0] b_imm;
	logic [18:0] j_imm;
	word_addr_t offset;

	assign opcode = instr_i[6:0];
	assign is_branch = (opcode == `BP_OP_BRANCH);
	assign is_jal = (opcode == `BP_OP_JAL);
	assign is_ctrl_o = is_branch | is_jal;

	// b-type imm[12:2]
	assign b_imm = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:9]};

	// j-type imm[20:2]
	assign j_imm = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:22]};

	// sign extend to a word offset
	always_comb begin
		if (is_branch) begin
			offset = {{(`BP_WADDR_W - 11){b_imm[10]}}, b_imm};
		end else begin
			offset = {{(`BP_WADDR_W - 19){j_imm[18]}}, j_imm};
		end
	end

	// target is only meaningful when is_ctrl_o is high
	assign target_o = pc_i + offset;

endmodule

/* hw/btb_lookup.sv */
`include "bp_defines.svh"

module btb_lookup
	import bp_pkg::*;
(
	input  word_addr_t  addr_i,
	input  btb_entry_t  entries_i [`BP_ENTRIES],
	output btb_lookup_t result_o,
	output logic [31:0] next_pc_o
);

	logic [`BP_ENTRIES-1:0] match_bits;
	logic hit;
	logic [`BP_IDX_W-1:0] hit_idx;
	word_addr_t sel_addr;

	// parallel tag compare, masked by valid
	always_comb begin
		for (int i = 0; i < `BP_ENTRIES; i++) begin
			match_bits[i] = entries_i[i].valid && (entries_i[i].tag == addr_i);
		end
	end

	// lowest matching index wins; tags are unique so at most one matches
	always_comb begin
		hit = 1'b0;
		hit_idx = '0;
		for (int i = `BP_ENTRIES - 1; i >= 0; i--) begin
			if (match_bits[i]) begin
				hit = 1'b1;
				hit_idx = `BP_IDX_W'(i);
			end
		end
	end

	assign result_o.hit = hit;
	assign result_o.idx = hit_idx;
	assign result_o.entry = entries_i[hit_idx];

	// weakly or strongly taken uses the stored target
	always_comb begin
		if (hit && (entries_i[hit_idx].ctr >= `BP_CTR_TAKEN)) begin
			sel_addr = entries_i[hit_idx].target;
		end else begin
			sel_addr = addr_i + word_addr_t'(1);
		end
	end

	assign next_pc_o = {sel_addr, 2'b00};

endmodule

/* hw/lru_tracker.sv */
`include "bp_defines.svh"

module lru_tracker (
	input  logic                   clock_i,
	input  logic                   reset,
	input  logic                   touch_i,
	input  logic [`BP_IDX_W-1:0]   touch_idx_i,
	input  logic                   touch_hit_i,
	input  logic [`BP_ENTRIES-1:0] valid_mask_i,
	output logic [`BP_IDX_W-1:0]   victim_idx_o
);

	// age 0 is most recent, valid entries hold distinct ages
	logic [`BP_IDX_W-1:0] age_q [`BP_ENTRIES];
	logic [`BP_IDX_W-1:0] touched_age;
	logic [`BP_ENTRIES-1:0] bump;

	assign touched_age = age_q[touch_idx_i];

	// decide which entries grow one step older
	always_comb begin
		for (int i = 0; i < `BP_ENTRIES; i++) begin
			if (i == touch_idx_i) begin
				bump[i] = 1'b0;
			end else if (touch_hit_i) begin
				// hit only shifts the entries younger than the touched one
				bump[i] = valid_mask_i[i] && (age_q[i] < touched_age);
			end else begin
				// allocation ages every other live entry
				bump[i] = valid_mask_i[i];
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (!reset) begin
			for (int i = 0; i < `BP_ENTRIES; i++) begin
				age_q[i] <= '0;
			end
		end else if (touch_i) begin
			for (int i = 0; i < `BP_ENTRIES; i++) begin
				if (i == touch_idx_i) begin
					age_q[i] <= '0;
				end else if (bump[i]) begin
					age_q[i] <= age_q[i] + 1'b1;
				end
			end
		end
	end

	// oldest entry, only unique once the table is full
	always_comb begin
		victim_idx_o = '0;
		for (int i = `BP_ENTRIES - 1; i >= 0; i--) begin
			if (age_q[i] == `BP_IDX_W'(`BP_ENTRIES - 1)) begin
				victim_idx_o = `BP_IDX_W'(i);
			end
		end
	end

endmodule

/* hw/btb_table.sv */
`include "bp_defines.svh"

module btb_table
	import bp_pkg::*;
(
	input  logic        clock_i,
	input  logic        reset,
	input  bp_update_t  update_i,
	input  logic        is_ctrl_i,
	input  word_addr_t  target_i,
	input  btb_lookup_t upd_lookup_i,
	output btb_entry_t  entries_o [`BP_ENTRIES]
);

	btb_entry_t entries_q [`BP_ENTRIES];
	logic [`BP_ENTRIES-1:0] valid_mask;
	logic free_found;
	logic [`BP_IDX_W-1:0] free_idx;
	logic [`BP_IDX_W-1:0] victim_idx;
	logic [`BP_IDX_W-1:0] wr_idx;
	logic do_train;
	logic [1:0] next_ctr;

	always_comb begin
		for (int i = 0; i < `BP_ENTRIES; i++) begin
			valid_mask[i] = entries_q[i].valid;
		end
	end

	// lowest invalid slot
	always_comb begin
		free_found = 1'b0;
		free_idx = '0;
		for (int i = `BP_ENTRIES - 1; i >= 0; i--) begin
			if (!valid_mask[i]) begin
				free_found = 1'b1;
				free_idx = `BP_IDX_W'(i);
			end
		end
	end

	// only branches and jal train, everything else passes by
	assign do_train = update_i.valid && is_ctrl_i;

	// hit slot first, then a free slot, then the lru victim
	always_comb begin
		if (upd_lookup_i.hit) begin
			wr_idx = upd_lookup_i.idx;
		end else if (free_found) begin
			wr_idx = free_idx;
		end else begin
			wr_idx = victim_idx;
		end
	end

	// saturating counter on a hit, fixed start value on allocation
	always_comb begin
		next_ctr = upd_lookup_i.entry.ctr;
		if (upd_lookup_i.hit) begin
			if (update_i.taken) begin
				if (next_ctr != 2'd3) begin
					next_ctr = next_ctr + 2'd1;
				end
			end else begin
				if (next_ctr != 2'd0) begin
					next_ctr = next_ctr - 2'd1;
				end
			end
		end else begin
			next_ctr = update_i.taken ? `BP_CTR_ALLOC_T : `BP_CTR_ALLOC_NT;
		end
	end

	always_ff @(posedge clock_i) begin
		if (!reset) begin
			for (int i = 0; i < `BP_ENTRIES; i++) begin
				entries_q[i] <= '0;
			end
		end else if (do_train) begin
			// tag rewrite on a hit is harmless, it already equals the pc
			entries_q[wr_idx] <= '{
				valid:  1'b1,
				tag:    update_i.pc,
				target: target_i,
				ctr:    next_ctr
			};
		end
	end

	// pre-update valid mask, so the allocated slot is not aged
	lru_tracker u_lru_tracker (
		.clock_i      (clock_i),
		.reset        (reset),
		.touch_i      (do_train),
		.touch_idx_i  (wr_idx),
		.touch_hit_i  (upd_lookup_i.hit),
		.valid_mask_i (valid_mask),
		.victim_idx_o (victim_idx)
	);

	assign entries_o = entries_q;

endmodule

/* hw/branch_predictor.sv */
`include "bp_defines.svh"

module branch_predictor
	import bp_pkg::*;
(
	input  logic        clock_i,
	input  logic        reset,
	input  word_addr_t  fetch_pc_i,
	input  bp_update_t  update_i,
	output logic [31:0] next_pc_o
);

	logic is_ctrl;
	word_addr_t target;
	btb_entry_t entries [`BP_ENTRIES];
	btb_lookup_t upd_lookup;

	// fetch side, same cycle prediction
	btb_lookup u_fetch_lookup (
		.addr_i    (fetch_pc_i),
		.entries_i (entries),
		.result_o  (),
		.next_pc_o (next_pc_o)
	);

	// training side
	branch_target_decoder u_branch_target_decoder (
		.instr_i   (update_i.instr),
		.pc_i      (update_i.pc),
		.is_ctrl_o (is_ctrl),
		.target_o  (target)
	);

	btb_lookup u_update_lookup (
		.addr_i    (update_i.pc),
		.entries_i (entries),
		.result_o  (upd_lookup),
		.next_pc_o ()
	);

	btb_table u_btb_table (
		.clock_i      (clock_i),
		.reset        (reset),
		.update_i     (update_i),
		.is_ctrl_i    (is_ctrl),
		.target_i     (target),
		.upd_lookup_i (upd_lookup),
		.entries_o    (entries)
	);

endmodule

/* tests/bp_ref_model.svh */
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

`include "bp_defines.svh"

// one resolved instruction as the model sees it
typedef struct packed {
	logic       valid;
	word_addr_t pc;
	logic       is_ctrl;
	word_addr_t target;
	logic       taken;
} train_t;

btb_entry_t ref_entry [`BP_ENTRIES];
int ref_age [`BP_ENTRIES];

// target word address from the pc and the signed byte immediate
function automatic word_addr_t calc_target(input word_addr_t pc, input int imm);
	return pc + word_addr_t'(imm >>> 2);
endfunction

function automatic void model_reset();
	for (int i = 0; i < `BP_ENTRIES; i++) begin
		ref_entry[i] = '0;
		ref_age[i] = 0;
	end
endfunction

function automatic int model_find(input word_addr_t pc);
	for (int i = 0; i < `BP_ENTRIES; i++) begin
		if (ref_entry[i].valid && (ref_entry[i].tag == pc)) begin
			return i;
		end
	end
	return -1;
endfunction

// taken prediction needs a hit and a counter of 2 or 3
function automatic logic [31:0] model_predict(input word_addr_t pc);
	int idx;
	idx = model_find(pc);
	if ((idx >= 0) && (ref_entry[idx].ctr >= 2'd2)) begin
		return {ref_entry[idx].target, 2'b00};
	end
	return {pc + word_addr_t'(1), 2'b00};
endfunction

function automatic void model_touch(input int idx, input logic hit);
	int old_age;
	old_age = ref_age[idx];
	for (int i = 0; i < `BP_ENTRIES; i++) begin
		if ((i != idx) && ref_entry[i].valid && (!hit || (ref_age[i] < old_age))) begin
			ref_age[i] = ref_age[i] + 1;
		end
	end
	ref_age[idx] = 0;
endfunction

function automatic void model_train(input train_t upd);
	int idx;
	int slot;
	if (!(upd.valid && upd.is_ctrl)) begin
		return;
	end
	idx = model_find(upd.pc);
	if (idx >= 0) begin
		if (upd.taken && (ref_entry[idx].ctr != 2'd3)) begin
			ref_entry[idx].ctr = ref_entry[idx].ctr + 2'd1;
		end else if (!upd.taken && (ref_entry[idx].ctr != 2'd0)) begin
			ref_entry[idx].ctr = ref_entry[idx].ctr - 2'd1;
		end
		ref_entry[idx].target = upd.target;
		model_touch(idx, 1'b1);
		return;
	end
	// lowest free slot, else the oldest entry
	slot = -1;
	for (int i = `BP_ENTRIES - 1; i >= 0; i--) begin
		if (!ref_entry[i].valid) begin
			slot = i;
		end
	end
	if (slot < 0) begin
		for (int i = 0; i < `BP_ENTRIES; i++) begin
			if (ref_age[i] == `BP_ENTRIES - 1) begin
				slot = i;
			end
		end
	end
	ref_entry[slot].valid = 1'b1;
	ref_entry[slot].tag = upd.pc;
	ref_entry[slot].target = upd.target;
	ref_entry[slot].ctr = upd.taken ? 2'd2 : 2'd1;
	model_touch(slot, 1'b0);
endfunction

`endif

/* tests/tb_branch_predictor.sv */
`include "bp_defines.svh"

module tb_branch_predictor
	import bp_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int SEED = 34882;
	localparam int NUM_RANDOM = 3000;
	localparam int RESET_TIMEOUT = 20;
	localparam int POOL_SIZE = 24;
	localparam int KIND_BRANCH = 0;
	localparam int KIND_JAL = 1;
	localparam int KIND_OTHER = 2;

	localparam word_addr_t PC_A = 30'h100;
	localparam word_addr_t PC_B = 30'h180;
	localparam word_addr_t PC_C = 30'h140;
	localparam word_addr_t PC_D = 30'h300;
	localparam word_addr_t PC_FILL = 30'h200;

	logic clock_i;
	logic reset;
	word_addr_t fetch_pc_i;
	bp_update_t update_i;
	logic [31:0] next_pc_o;
	word_addr_t pool [POOL_SIZE];

	`include "bp_ref_model.svh"

	// update driven last cycle and taken into the model on the next edge
	train_t pending;

	branch_predictor u_branch_predictor (
		.clock_i    (clock_i),
		.reset      (reset),
		.fetch_pc_i (fetch_pc_i),
		.update_i   (update_i),
		.next_pc_o  (next_pc_o)
	);

	initial begin
		clock_i = 1'b0;
	end

	always #10 clock_i = ~clock_i;

	initial begin
		reset = 1'b0;
		repeat (2) @(posedge clock_i);
		reset <= 1'b1;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "stopping on the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			report_failure($sformatf("FAILED at time %0t: %s = 0x%08h, expected 0x%08h",
				$time, name, actual, expected));
		end
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (reset !== 1'b1) begin
			@(posedge clock_i);
			cycles++;
			if (cycles > RESET_TIMEOUT) begin
				report_failure("reset was not released within the expected number of cycles");
			end
		end
	endtask

	function automatic logic [31:0] seq_pc(input word_addr_t pc);
		return {pc + word_addr_t'(1), 2'b00};
	endfunction

	function automatic logic [31:0] taken_pc(input word_addr_t pc, input int imm);
		return {calc_target(pc, imm), 2'b00};
	endfunction

	// even byte immediate with 13 bits for branches and 21 bits for jal
	function automatic int draw_imm(input int kind);
		logic [20:0] raw;
		raw = 21'($urandom);
		raw[0] = 1'b0;
		if (kind == KIND_BRANCH) begin
			return int'({{19{raw[12]}}, raw[12:0]});
		end
		return int'({{11{raw[20]}}, raw});
	endfunction

	function automatic logic [31:0] encode_instr(input int kind, input int imm);
		logic [31:0] ib;
		logic [31:0] fill;
		logic [6:0] other_op;
		ib = imm;
		fill = $urandom;
		case (fill[1:0])
			2'd0: other_op = 7'b0110011;
			2'd1: other_op = 7'b0010011;
			// jalr must not train the buffer
			2'd2: other_op = 7'b1100111;
			default: other_op = 7'b0000011;
		endcase
		if (kind == KIND_BRANCH) begin
			return {ib[12], ib[10:5], fill[24:12], ib[4:1], ib[11], `BP_OP_BRANCH};
		end else if (kind == KIND_JAL) begin
			return {ib[20], ib[10:1], ib[11], ib[19:12], fill[11:7], `BP_OP_JAL};
		end
		return {fill[31:7], other_op};
	endfunction

	// drive on the rising edge and compare at the falling edge
	task automatic run_cycle(input word_addr_t fpc, input logic uvalid, input word_addr_t upc,
			input int kind, input int imm, input logic taken);
		bp_update_t upd;
		upd.valid = uvalid;
		upd.pc = upc;
		upd.instr = encode_instr(kind, imm);
		upd.taken = taken;
		@(posedge clock_i);
		model_train(pending);
		fetch_pc_i <= fpc;
		update_i <= upd;
		pending.valid = uvalid;
		pending.pc = upc;
		pending.is_ctrl = (kind != KIND_OTHER);
		pending.target = calc_target(upc, imm);
		pending.taken = taken;
		@(negedge clock_i);
		check_value("next_pc_o", next_pc_o, model_predict(fpc));
	endtask

	task automatic expect_fetch(input word_addr_t pc, input logic [31:0] expected);
		run_cycle(pc, 1'b0, pc, KIND_OTHER, 0, 1'b0);
		check_value("next_pc_o", next_pc_o, expected);
	endtask

	task automatic check_single_training();
		run_cycle(PC_A, 1'b1, PC_A, KIND_BRANCH, 64, 1'b1);
		expect_fetch(PC_A, taken_pc(PC_A, 64));
		run_cycle(PC_B, 1'b1, PC_B, KIND_BRANCH, -24, 1'b0);
		expect_fetch(PC_B, seq_pc(PC_B));
	endtask

	task automatic check_saturation();
		// counter of A goes from 2 to 0
		repeat (2) run_cycle(PC_A, 1'b1, PC_A, KIND_BRANCH, 64, 1'b0);
		expect_fetch(PC_A, seq_pc(PC_A));
		repeat (3) run_cycle(PC_A, 1'b1, PC_A, KIND_BRANCH, 64, 1'b1);
		expect_fetch(PC_A, taken_pc(PC_A, 64));
		// the counter stays at 3 so one not-taken still leaves it taken
		run_cycle(PC_A, 1'b1, PC_A, KIND_BRANCH, 64, 1'b1);
		run_cycle(PC_A, 1'b1, PC_A, KIND_BRANCH, 64, 1'b0);
		expect_fetch(PC_A, taken_pc(PC_A, 64));
	endtask

	task automatic check_ignored_opcodes();
		for (int i = 0; i < 8; i++) begin
			run_cycle(PC_A, 1'b1, (i % 2 == 0) ? PC_A : PC_C, KIND_OTHER, -100, 1'(i));
		end
		expect_fetch(PC_A, taken_pc(PC_A, 64));
		expect_fetch(PC_C, seq_pc(PC_C));
	endtask

	task automatic check_replacement();
		word_addr_t fill_pc;
		for (int i = 0; i < `BP_ENTRIES - 2; i++) begin
			fill_pc = PC_FILL + word_addr_t'(2 * i);
			run_cycle(fill_pc, 1'b1, fill_pc, KIND_BRANCH, 40, 1'b1);
		end
		// touching B then A leaves the first fill entry as the oldest
		run_cycle(PC_B, 1'b1, PC_B, KIND_BRANCH, -24, 1'b1);
		run_cycle(PC_A, 1'b1, PC_A, KIND_BRANCH, 64, 1'b1);
		run_cycle(PC_D, 1'b1, PC_D, KIND_JAL, 2048, 1'b1);
		expect_fetch(PC_A, taken_pc(PC_A, 64));
		expect_fetch(PC_B, taken_pc(PC_B, -24));
		expect_fetch(PC_D, taken_pc(PC_D, 2048));
		for (int i = 0; i < `BP_ENTRIES - 2; i++) begin
			fill_pc = PC_FILL + word_addr_t'(2 * i);
			if (i == 0) begin
				expect_fetch(fill_pc, seq_pc(fill_pc));
			end else begin
				expect_fetch(fill_pc, taken_pc(fill_pc, 40));
			end
		end
	endtask

	task automatic run_random();
		word_addr_t fpc;
		word_addr_t upc;
		int kind;
		for (int n = 0; n < NUM_RANDOM; n++) begin
			fpc = pool[$urandom_range(POOL_SIZE - 1, 0)];
			upc = pool[$urandom_range(POOL_SIZE - 1, 0)];
			// fetch and train the same pc in one cycle now and then
			if ($urandom_range(7, 0) == 0) begin
				upc = fpc;
			end
			kind = $urandom_range(2, 0);
			run_cycle(fpc, ($urandom_range(3, 0) != 0), upc, kind, draw_imm(kind),
				1'($urandom));
		end
	endtask

	initial begin
		void'($urandom(SEED));
		fetch_pc_i = '0;
		update_i = '0;
		pending = '0;
		model_reset();
		for (int i = 0; i < POOL_SIZE; i++) begin
			pool[i] = word_addr_t'(30'h4000 + 3 * i);
		end
		wait_reset_release();
		for (int i = 0; i < 8; i++) begin
			expect_fetch(pool[i], seq_pc(pool[i]));
		end
		check_single_training();
		check_saturation();
		check_ignored_opcodes();
		check_replacement();
		run_random();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* tb.f */
+incdir+hw
+incdir+tests
hw/bp_pkg.sv
hw/branch_target_decoder.sv
hw/btb_lookup.sv
hw/lru_tracker.sv
hw/btb_table.sv
hw/branch_predictor.sv
tests/tb_branch_predictor.sv
